// ==== verilog/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

	localparam int XLEN        = 32;
	localparam int TAG_W       = 6;
	localparam int RS_DEPTH    = 4;  // also the dispatch credits after reset
	localparam int MLU_STAGES  = 3;
	localparam int FUQ_DEPTH   = 4;  // also the issue credits after reset
	localparam int CDB_CREDITS = 2;

	localparam int RS_IDX_W    = $clog2(RS_DEPTH);
	localparam int ISSUE_CNT_W = $clog2(FUQ_DEPTH + 1);
	localparam int FUQ_IDX_W   = $clog2(FUQ_DEPTH);
	localparam int FUQ_CNT_W   = $clog2(FUQ_DEPTH + 1);
	localparam int CDB_CNT_W   = $clog2(CDB_CREDITS + 1);
	localparam int MLU_SPLIT   = XLEN / 2;     // operand b is cut here into two partial products
	localparam int PROD_W      = 2 * XLEN + 2; // product of two 33-bit signed operands

	localparam logic [ISSUE_CNT_W-1:0] ISSUE_CREDIT_INIT = ISSUE_CNT_W'(FUQ_DEPTH);
	localparam logic [FUQ_CNT_W-1:0]   FUQ_FULL          = FUQ_CNT_W'(FUQ_DEPTH);
	localparam logic [CDB_CNT_W-1:0]   CDB_CREDIT_INIT   = CDB_CNT_W'(CDB_CREDITS);

	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	typedef enum logic [1:0] {
		MULT_LO,
		MULT_HI_SS,
		MULT_HI_SU,
		MULT_HI_UU
	} mult_func_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	// same 32 bits, seen whole or split into R-type fields
	typedef union packed {
		logic [31:0] raw;
		r_type_t     r;
	} inst_word_u;

	typedef struct packed {
		logic             ready;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  value;
	} operand_t;

	typedef struct packed {
		inst_word_u       inst;
		logic [TAG_W-1:0] dest_tag;
		operand_t         src_a;
		operand_t         src_b;
	} dispatch_t;

	typedef struct packed {
		mult_func_e       func;
		logic [TAG_W-1:0] dest_tag;
		logic [XLEN-1:0]  opa;
		logic [XLEN-1:0]  opb;
	} issue_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  value;
	} wakeup_t;

	typedef struct packed {
		logic [TAG_W-1:0] dest_tag;
		logic             illegal;
		logic [XLEN-1:0]  value;
	} result_t;

endpackage

`default_nettype wire

// ==== verilog/mult_decode.sv ====
`default_nettype none

module mult_decode (
	input  mult_pkg::inst_word_u inst,
	output mult_pkg::mult_func_e func,
	output logic                 illegal
);

	logic bad_word;
	logic not_muldiv;

	always_comb begin
		case (inst.r.funct3)
			3'd0:    func = mult_pkg::MULT_LO;    // mul
			3'd1:    func = mult_pkg::MULT_HI_SS; // mulh
			3'd2:    func = mult_pkg::MULT_HI_SU; // mulhsu
			3'd3:    func = mult_pkg::MULT_HI_UU; // mulhu
			default: func = mult_pkg::MULT_LO;    // div group, flagged below
		endcase
	end

	always_comb begin
		bad_word = (inst.raw == '0) || (inst.raw == '1);
		not_muldiv = (inst.r.opcode != mult_pkg::OPCODE_OP) ||
			(inst.r.funct7 != mult_pkg::FUNCT7_MULDIV) ||
			inst.r.funct3[2];
		// still dispatched, the result comes back zero with illegal set
		illegal = bad_word || not_muldiv;
	end

endmodule

`default_nettype wire

// ==== verilog/mult_rs.sv ====
`default_nettype none

module mult_rs (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 squash,
	input  logic                 dispatch_valid,
	input  mult_pkg::dispatch_t  dispatch,
	input  mult_pkg::mult_func_e func,
	input  logic                 illegal,
	input  mult_pkg::wakeup_t    wakeup,
	input  logic                 fu_credit,
	output logic                 issue_valid,
	output mult_pkg::issue_t     issue,
	output logic                 issue_illegal,
	output logic                 dispatch_credit
);

	typedef struct packed {
		logic                       illegal;
		mult_pkg::mult_func_e       func;
		logic [mult_pkg::TAG_W-1:0] dest_tag;
		mult_pkg::operand_t         src_a;
		mult_pkg::operand_t         src_b;
	} rs_entry_t;

	rs_entry_t                                              ent [mult_pkg::RS_DEPTH];
	rs_entry_t                                              new_ent;
	logic [mult_pkg::RS_DEPTH-1:0]                          ent_valid;
	logic [mult_pkg::RS_DEPTH-1:0][mult_pkg::RS_DEPTH-1:0]  older; // older[i][j] set when i is ahead of j
	logic [mult_pkg::RS_DEPTH-1:0]                          ready;
	logic [mult_pkg::RS_IDX_W-1:0]                          free_idx;
	logic [mult_pkg::RS_IDX_W-1:0]                          sel_idx;
	logic                                                   sel_found;
	logic                                                   full;
	logic                                                   dispatch_fire;
	logic [mult_pkg::ISSUE_CNT_W-1:0]                       issue_credits;

	function automatic mult_pkg::operand_t wake(mult_pkg::operand_t op, mult_pkg::wakeup_t wk);
		mult_pkg::operand_t res;
		res = op;
		if (!op.ready && wk.valid && (wk.tag == op.tag)) begin
			res.ready = 1'b1;
			res.value = wk.value;
		end
		return res;
	endfunction

	always_comb begin
		full = &ent_valid;
		dispatch_fire = dispatch_valid && !full && !squash;
		free_idx = '0;
		for (int i = mult_pkg::RS_DEPTH - 1; i >= 0; i--) begin
			if (!ent_valid[i])
				free_idx = i[mult_pkg::RS_IDX_W-1:0]; // lowest free slot
		end
		new_ent.illegal = illegal;
		new_ent.func = func;
		new_ent.dest_tag = dispatch.dest_tag;
		new_ent.src_a = wake(dispatch.src_a, wakeup); // same-cycle wakeup still counts
		new_ent.src_b = wake(dispatch.src_b, wakeup);
	end

	// oldest ready entry with nothing ready ahead of it
	always_comb begin
		logic blocked;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < mult_pkg::RS_DEPTH; i++)
			ready[i] = ent_valid[i] && ent[i].src_a.ready && ent[i].src_b.ready;
		for (int i = 0; i < mult_pkg::RS_DEPTH; i++) begin
			blocked = 1'b0;
			for (int j = 0; j < mult_pkg::RS_DEPTH; j++)
				blocked = blocked | (ready[j] & older[j][i]);
			if (ready[i] && !blocked) begin
				sel_found = 1'b1;
				sel_idx = i[mult_pkg::RS_IDX_W-1:0];
			end
		end
	end

	assign issue_valid = sel_found && (issue_credits != '0);

	always_comb begin
		issue.func = ent[sel_idx].func;
		issue.dest_tag = ent[sel_idx].dest_tag;
		issue.opa = ent[sel_idx].src_a.value;
		issue.opb = ent[sel_idx].src_b.value;
		issue_illegal = ent[sel_idx].illegal;
	end

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			ent_valid <= '0;
			older <= '0;
			issue_credits <= mult_pkg::ISSUE_CREDIT_INIT;
			dispatch_credit <= 1'b0;
		end else begin
			dispatch_credit <= issue_valid; // slot frees on issue
			if (issue_valid)
				ent_valid[sel_idx] <= 1'b0;
			if (dispatch_fire) begin
				ent_valid[free_idx] <= 1'b1;
				older[free_idx] <= '0;
				for (int j = 0; j < mult_pkg::RS_DEPTH; j++)
					older[j][free_idx] <= ent_valid[j];
			end
			case ({issue_valid, fu_credit})
				2'b10:   issue_credits <= issue_credits - 1'b1;
				2'b01:   issue_credits <= issue_credits + 1'b1;
				default: issue_credits <= issue_credits;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < mult_pkg::RS_DEPTH; i++) begin
			if (ent_valid[i]) begin
				ent[i].src_a <= wake(ent[i].src_a, wakeup);
				ent[i].src_b <= wake(ent[i].src_b, wakeup);
			end
		end
		if (dispatch_fire)
			ent[free_idx] <= new_ent;
	end

	// upstream holds a credit for each free slot
	a_dispatch_not_full: assert property (@(posedge clock) disable iff (reset)
		dispatch_valid |-> !full)
		else $error("mult_rs: dispatch with every entry occupied");

	// a returned credit must belong to an earlier issue
	a_credit_bound: assert property (@(posedge clock) disable iff (reset)
		(fu_credit && !issue_valid) |-> (issue_credits < mult_pkg::ISSUE_CREDIT_INIT))
		else $error("mult_rs: issue credits above queue depth");

endmodule

`default_nettype wire

// ==== verilog/mlu.sv ====
`default_nettype none

module mlu (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      flush,
	input  logic                      in_valid,
	input  mult_pkg::mult_func_e      func,
	input  logic [mult_pkg::XLEN-1:0] opa,
	input  logic [mult_pkg::XLEN-1:0] opb,
	output logic                      out_valid,
	output logic [mult_pkg::XLEN-1:0] result
);

	// extend, partial products, sum and select: one register each
	if (mult_pkg::MLU_STAGES != 3) begin : g_stage_check
		$error("mlu datapath is built for three stages");
	end

	logic [mult_pkg::MLU_STAGES-1:0]      vld;
	logic                                 sign_a;
	logic                                 sign_b;
	mult_pkg::mult_func_e                 func_s1;
	mult_pkg::mult_func_e                 func_s2;
	logic signed [mult_pkg::XLEN:0]       a_s1;
	logic signed [mult_pkg::XLEN:0]       b_s1;
	logic signed [mult_pkg::PROD_W-1:0]   pp_lo_s2;
	logic signed [mult_pkg::PROD_W-1:0]   pp_hi_s2;
	logic signed [mult_pkg::PROD_W-1:0]   prod;

	always_comb begin
		sign_a = (func == mult_pkg::MULT_HI_SS) || (func == mult_pkg::MULT_HI_SU);
		sign_b = (func == mult_pkg::MULT_HI_SS);
	end

	always_ff @(posedge clock) begin
		if (reset || flush)
			vld <= '0;
		else
			vld <= {vld[mult_pkg::MLU_STAGES-2:0], in_valid};
	end

	assign out_valid = vld[mult_pkg::MLU_STAGES-1];

	always_ff @(posedge clock) begin
		// stage 1: one extra bit carries the sign or a zero
		a_s1 <= {sign_a & opa[mult_pkg::XLEN-1], opa};
		b_s1 <= {sign_b & opb[mult_pkg::XLEN-1], opb};
		func_s1 <= func;
		// stage 2: low half of b unsigned, upper part keeps the sign
		pp_lo_s2 <= a_s1 * $signed({1'b0, b_s1[mult_pkg::MLU_SPLIT-1:0]});
		pp_hi_s2 <= a_s1 * $signed(b_s1[mult_pkg::XLEN:mult_pkg::MLU_SPLIT]);
		func_s2 <= func_s1;
		// stage 3
		if (func_s2 == mult_pkg::MULT_LO)
			result <= prod[mult_pkg::XLEN-1:0];
		else
			result <= prod[2*mult_pkg::XLEN-1:mult_pkg::XLEN];
	end

	assign prod = (pp_hi_s2 <<< mult_pkg::MLU_SPLIT) + pp_lo_s2;

endmodule

`default_nettype wire

// ==== verilog/fu_mult.sv ====
`default_nettype none

module fu_mult (
	input  logic              clock,
	input  logic              reset,
	input  logic              squash,
	input  logic              issue_valid,
	input  mult_pkg::issue_t  issue,
	input  logic              issue_illegal,
	input  logic              cdb_credit,
	output logic              fu_credit,
	output logic              result_valid,
	output mult_pkg::result_t result
);

	typedef struct packed {
		logic [mult_pkg::TAG_W-1:0] dest_tag;
		logic                       illegal;
	} meta_t;

	meta_t                          meta [mult_pkg::MLU_STAGES]; // runs beside the mlu stages
	mult_pkg::result_t              fuq [mult_pkg::FUQ_DEPTH];
	mult_pkg::result_t              q_in;
	logic [mult_pkg::FUQ_IDX_W-1:0] wr_ptr;
	logic [mult_pkg::FUQ_IDX_W-1:0] rd_ptr;
	logic [mult_pkg::FUQ_CNT_W-1:0] count;
	logic [mult_pkg::CDB_CNT_W-1:0] out_credits;
	logic                           mlu_valid;
	logic [mult_pkg::XLEN-1:0]      mlu_result;
	logic                           push;

	mlu u_mlu (
		.clock(clock),
		.reset(reset),
		.flush(squash),
		.in_valid(issue_valid),
		.func(issue.func),
		.opa(issue.opa),
		.opb(issue.opb),
		.out_valid(mlu_valid),
		.result(mlu_result)
	);

	always_ff @(posedge clock) begin
		meta[0] <= '{dest_tag: issue.dest_tag, illegal: issue_illegal};
		for (int i = 1; i < mult_pkg::MLU_STAGES; i++)
			meta[i] <= meta[i-1];
	end

	always_comb begin
		q_in.dest_tag = meta[mult_pkg::MLU_STAGES-1].dest_tag;
		q_in.illegal = meta[mult_pkg::MLU_STAGES-1].illegal;
		q_in.value = q_in.illegal ? '0 : mlu_result;
	end

	assign push = mlu_valid && !squash;
	assign result_valid = (count != '0) && (out_credits != '0);
	assign fu_credit = result_valid; // queue slot frees as the result leaves
	assign result = fuq[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_credits <= mult_pkg::CDB_CREDIT_INIT;
		end else begin
			case ({result_valid, cdb_credit})
				2'b10:   out_credits <= out_credits - 1'b1;
				2'b01:   out_credits <= out_credits + 1'b1;
				default: out_credits <= out_credits;
			endcase
			if (squash) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end else begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (result_valid)
					rd_ptr <= rd_ptr + 1'b1;
				case ({push, result_valid})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			fuq[wr_ptr] <= q_in;
	end

	// issue credits in mult_rs keep in-flight plus queued within depth
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		push |-> (count != mult_pkg::FUQ_FULL))
		else $error("fu_mult: result pushed into a full queue");

	a_cdb_credit_bound: assert property (@(posedge clock) disable iff (reset)
		cdb_credit |-> (out_credits != mult_pkg::CDB_CREDIT_INIT))
		else $error("fu_mult: output credits above initial count");

endmodule

`default_nettype wire

// ==== verilog/mult_subsys.sv ====
`default_nettype none

module mult_subsys (
	input  logic                clock,
	input  logic                reset,
	input  logic                squash,
	input  logic                dispatch_valid,
	input  mult_pkg::dispatch_t dispatch,
	input  mult_pkg::wakeup_t   wakeup,
	input  logic                cdb_credit,
	output logic                dispatch_credit,
	output logic                result_valid,
	output mult_pkg::result_t   result
);

	mult_pkg::mult_func_e func;
	logic                 illegal;
	logic                 issue_valid;
	mult_pkg::issue_t     issue;
	logic                 issue_illegal;
	logic                 fu_credit;

	mult_decode u_decode (
		.inst(dispatch.inst),
		.func(func),
		.illegal(illegal)
	);

	mult_rs u_rs (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.func(func),
		.illegal(illegal),
		.wakeup(wakeup),
		.fu_credit(fu_credit),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_illegal(issue_illegal),
		.dispatch_credit(dispatch_credit)
	);

	fu_mult u_fu (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_illegal(issue_illegal),
		.cdb_credit(cdb_credit),
		.fu_credit(fu_credit),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== verif/mult_subsys_tb.sv ====
`default_nettype none

module mult_subsys_tb;

	typedef struct packed {
		logic [2:0]  funct3;
		logic        use_raw;
		logic [31:0] raw;
		logic [31:0] opa;
		logic [31:0] opb;
		logic        b_wait;
		logic [5:0]  b_tag;
		logic [31:0] exp_value;
		logic        exp_illegal;
	} row_t;

	logic                clock;
	logic                reset;
	logic                squash;
	logic                dispatch_valid;
	mult_pkg::dispatch_t dispatch;
	mult_pkg::wakeup_t   wakeup;
	logic                cdb_credit;
	logic                dispatch_credit;
	logic                result_valid;
	mult_pkg::result_t   result;

	row_t        tbl [$];
	logic        pending [64]; // scoreboard indexed by dest_tag
	logic        woke [64];
	logic [31:0] exp_val [64];
	logic        exp_ill [64];
	int          credits;      // upstream copy of the dispatch credits
	int          owed;         // results consumed but not yet credited back
	int          errors;
	int          results_seen;
	int          sent;
	int          outstanding;
	logic [5:0]  next_tag;
	logic        cdb_hold;
	logic        wk_pend;
	int          wk_delay;
	logic [5:0]  wk_tag;
	logic [5:0]  wk_dest;
	logic [31:0] wk_value;

	mult_subsys dut0 (
		.clock(clock),
		.reset(reset),
		.squash(squash),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.wakeup(wakeup),
		.cdb_credit(cdb_credit),
		.dispatch_credit(dispatch_credit),
		.result_valid(result_valid),
		.result(result)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// product of the zero or sign extended operands mod 2**64
	function automatic logic [31:0] ref_mul(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] xa;
		logic [63:0] xb;
		logic [63:0] p;
		xa = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
		xb = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
		p = xa * xb;
		return (f3 == 3'd0) ? p[31:0] : p[63:32];
	endfunction

	function automatic mult_pkg::inst_word_u mk_inst(input logic [2:0] f3);
		mult_pkg::inst_word_u w;
		w.r.funct7 = 7'b0000001; // muldiv
		w.r.rs2 = 5'd2;
		w.r.rs1 = 5'd1;
		w.r.funct3 = f3;
		w.r.rd = 5'd3;
		w.r.opcode = 7'b0110011;
		return w;
	endfunction

	task automatic add_row(input logic [2:0] f3, input logic use_raw, input logic [31:0] raw,
			input logic [31:0] a, input logic [31:0] b, input logic bw, input logic [5:0] bt,
			input logic [31:0] e, input logic ill);
		tbl.push_back('{f3, use_raw, raw, a, b, bw, bt, e, ill});
	endtask

	task automatic end_run();
		$display("results checked %0d, dispatched %0d, errors %0d", results_seen, sent, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_result();
		logic [5:0] t;
		t = result.dest_tag;
		results_seen++;
		if (!pending[t]) begin
			errors++;
			$display("unexpected or repeated result for tag %0d at time %0t", t, $time);
		end else begin
			if (!woke[t]) begin
				errors++;
				$display("result for tag %0d came back before its wakeup, time %0t", t, $time);
			end
			if (result.value != exp_val[t]) begin
				errors++;
				$display("FAILED time %0t result.value tag %0d: got %h expected %h",
					$time, t, result.value, exp_val[t]);
			end
			if (result.illegal != exp_ill[t]) begin
				errors++;
				$display("FAILED time %0t result.illegal tag %0d: got %b expected %b",
					$time, t, result.illegal, exp_ill[t]);
			end
			pending[t] = 1'b0;
			outstanding--;
		end
	endtask

	// sample at the falling edge and drive the next defaults
	task automatic tick();
		@(negedge clock);
		if (dispatch_credit)
			credits++;
		if (credits > mult_pkg::RS_DEPTH) begin
			errors++;
			$display("more dispatch credits returned than entries, time %0t", $time);
		end
		cdb_credit = 1'b0;
		if (!cdb_hold && owed > 0 && ($urandom % 3) != 0) begin
			cdb_credit = 1'b1; // random gap before giving a credit back
			owed--;
		end
		if (result_valid) begin
			check_result();
			owed++;
		end
		dispatch_valid = 1'b0;
		squash = 1'b0;
		wakeup = '0;
		if (wk_pend) begin
			if (wk_delay == 0) begin
				wakeup.valid = 1'b1;
				wakeup.tag = wk_tag;
				wakeup.value = wk_value;
				woke[wk_dest] = 1'b1;
				wk_pend = 1'b0;
			end else begin
				wk_delay--;
			end
		end
	endtask

	task automatic send(input mult_pkg::inst_word_u inst, input logic [31:0] a,
			input logic [31:0] b, input logic bw, input logic [5:0] bt,
			input logic [31:0] e, input logic ill);
		int n;
		int d;
		n = 0;
		tick();
		while ((credits == 0 || (bw && (wk_pend || wakeup.valid))) && n < 200) begin
			tick();
			n++;
		end
		if (n == 200) begin
			errors++;
			$display("timed out waiting for a dispatch credit");
			end_run();
		end
		dispatch_valid = 1'b1;
		dispatch.inst = inst;
		dispatch.dest_tag = next_tag;
		dispatch.src_a.ready = 1'b1;
		dispatch.src_a.tag = 6'd0;
		dispatch.src_a.value = a;
		dispatch.src_b.ready = !bw;
		dispatch.src_b.tag = bt;
		dispatch.src_b.value = bw ? ~b : b; // stale value until the wakeup
		pending[next_tag] = 1'b1;
		woke[next_tag] = !bw;
		exp_val[next_tag] = e;
		exp_ill[next_tag] = ill;
		if (bw) begin
			d = $urandom % 4;
			wk_tag = bt;
			wk_dest = next_tag;
			wk_value = b;
			if (d == 0) begin
				wakeup.valid = 1'b1; // same cycle as the dispatch
				wakeup.tag = bt;
				wakeup.value = b;
				woke[next_tag] = 1'b1;
			end else begin
				wk_pend = 1'b1;
				wk_delay = d - 1;
			end
		end
		credits--;
		outstanding++;
		sent++;
		next_tag++;
	endtask

	task automatic send_random();
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		f3 = $urandom % 4;
		a = $urandom;
		b = $urandom;
		send(mk_inst(f3), a, b, 1'b0, 6'd0, ref_mul(f3, a, b), 1'b0);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((outstanding != 0 || owed != 0 || wk_pend) && n < 400) begin
			tick();
			n++;
		end
		if (n == 400) begin
			errors++;
			$display("timed out with %0d results still missing", outstanding);
			end_run();
		end
	endtask

	initial begin
		mult_pkg::inst_word_u inst;
		int unsigned seed_dummy;
		int n;
		int idle;
		int res_base;
		int sent_base;
		seed_dummy = $urandom(50);
		reset = 1'b1;
		squash = 1'b0;
		dispatch_valid = 1'b0;
		dispatch = '0;
		wakeup = '0;
		cdb_credit = 1'b0;
		credits = mult_pkg::RS_DEPTH;
		owed = 0;
		errors = 0;
		results_seen = 0;
		sent = 0;
		outstanding = 0;
		next_tag = 6'd1;
		cdb_hold = 1'b0;
		wk_pend = 1'b0;
		wk_delay = 0;
		for (int i = 0; i < 64; i++) begin
			pending[i] = 1'b0;
			woke[i] = 1'b0;
		end
		// funct3 use-raw raw a b b-waits b-tag expected-value expected-illegal
		add_row(3'd0, 0, 32'h0, 32'h00000007, 32'h00000006, 0, 6'd0, 32'h0000002a, 0);
		add_row(3'd0, 0, 32'h0, 32'hffffffff, 32'hffffffff, 0, 6'd0, 32'h00000001, 0);
		add_row(3'd0, 0, 32'h0, 32'h80000000, 32'h80000000, 0, 6'd0, 32'h00000000, 0);
		add_row(3'd1, 0, 32'h0, 32'hffffffff, 32'hffffffff, 0, 6'd0, 32'h00000000, 0);
		add_row(3'd1, 0, 32'h0, 32'h80000000, 32'h80000000, 0, 6'd0, 32'h40000000, 0);
		add_row(3'd1, 0, 32'h0, 32'h80000000, 32'h7fffffff, 0, 6'd0, 32'hc0000000, 0);
		add_row(3'd2, 0, 32'h0, 32'hffffffff, 32'hffffffff, 0, 6'd0, 32'hffffffff, 0);
		add_row(3'd2, 0, 32'h0, 32'h80000000, 32'h80000000, 0, 6'd0, 32'hc0000000, 0);
		add_row(3'd3, 0, 32'h0, 32'hffffffff, 32'hffffffff, 0, 6'd0, 32'hfffffffe, 0);
		add_row(3'd3, 0, 32'h0, 32'h80000000, 32'h00000002, 0, 6'd0, 32'h00000001, 0);
		add_row(3'd1, 0, 32'h0, 32'h12345678, 32'h00010000, 1, 6'd60, 32'h00001234, 0);
		add_row(3'd0, 0, 32'h0, 32'hfffffffd, 32'h00000005, 1, 6'd61, 32'hfffffff1, 0);
		add_row(3'd3, 0, 32'h0, 32'h00010000, 32'h00010000, 1, 6'd62, 32'h00000001, 0);
		add_row(3'd0, 1, 32'h002081b3, 32'h3, 32'h4, 0, 6'd0, 32'h0, 1); // add
		add_row(3'd0, 1, 32'h00000000, 32'h3, 32'h4, 0, 6'd0, 32'h0, 1);
		add_row(3'd0, 1, 32'h00a08093, 32'h3, 32'h4, 0, 6'd0, 32'h0, 1); // addi
		repeat (2) @(negedge clock);
		reset = 1'b0;
		if (dispatch_credit !== 1'b0) begin
			errors++;
			$display("FAILED time %0t dispatch_credit after reset: got %b expected 0",
				$time, dispatch_credit);
		end
		if (result_valid !== 1'b0) begin
			errors++;
			$display("FAILED time %0t result_valid after reset: got %b expected 0",
				$time, result_valid);
		end
		foreach (tbl[i]) begin
			if (tbl[i].use_raw)
				inst.raw = tbl[i].raw;
			else
				inst = mk_inst(tbl[i].funct3);
			send(inst, tbl[i].opa, tbl[i].opb, tbl[i].b_wait, tbl[i].b_tag,
				tbl[i].exp_value, tbl[i].exp_illegal);
		end
		drain();

		// dispatch must run dry while the data bus is stalled
		cdb_hold = 1'b1;
		res_base = results_seen;
		sent_base = sent;
		n = 0;
		idle = 0;
		while (!(credits == 0 && idle >= 30) && n < 300) begin
			if (credits > 0) begin
				send_random();
				idle = 0;
			end else begin
				tick();
				idle++;
			end
			n++;
		end
		if (n == 300) begin
			errors++;
			$display("dispatch credits never ran out with the data bus stalled");
		end
		if (results_seen - res_base > mult_pkg::CDB_CREDITS) begin
			errors++;
			$display("%0d results without returned credits", results_seen - res_base);
		end
		if (sent - sent_base > mult_pkg::CDB_CREDITS + mult_pkg::RS_DEPTH +
				mult_pkg::FUQ_DEPTH + mult_pkg::MLU_STAGES) begin
			errors++;
			$display("%0d dispatches accepted while stalled", sent - sent_base);
		end
		cdb_hold = 1'b0;
		drain();

		// squash with work in flight and refill
		repeat (mult_pkg::RS_DEPTH)
			send_random();
		tick();
		tick();
		squash = 1'b1;
		credits = mult_pkg::RS_DEPTH;
		outstanding = 0;
		wk_pend = 1'b0;
		for (int i = 0; i < 64; i++)
			pending[i] = 1'b0;
		repeat (mult_pkg::RS_DEPTH)
			send_random();
		drain();
		repeat (20)
			tick(); // stray results from squashed tags would show here
		if (credits != mult_pkg::RS_DEPTH) begin
			errors++;
			$display("dispatch credits end at %0d instead of %0d", credits, mult_pkg::RS_DEPTH);
		end
		end_run();
	end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/mult_pkg.sv
verilog/mult_decode.sv
verilog/mult_rs.sv
verilog/mlu.sv
verilog/fu_mult.sv
verilog/mult_subsys.sv
verif/mult_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mult_subsys

sources:
  - verilog/mult_pkg.sv
  - verilog/mult_decode.sv
  - verilog/mult_rs.sv
  - verilog/mlu.sv
  - verilog/fu_mult.sv
  - verilog/mult_subsys.sv
  - target: test
    files:
      - verif/mult_subsys_tb.sv
